/* scoreboard.f */
+incdir+logic
logic/sb_pkg.sv
logic/sb_pointers.sv
logic/sb_entry_store.sv
logic/sb_clobber.sv
logic/sb_operand_fwd.sv
logic/scoreboard.sv
tests/tb_scoreboard.sv

/* Bender.yml */
package:
  name: scoreboard

sources:
  - include_dirs:
      - logic
    files:
      - logic/sb_pkg.sv
      - logic/sb_pointers.sv
      - logic/sb_entry_store.sv
      - logic/sb_clobber.sv
      - logic/sb_operand_fwd.sv
      - logic/scoreboard.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_scoreboard.sv

/* tests/sb_stimulus.txt */
# commands: TEST name, INSERT fu rd, WB id data, COMMIT, FLUSH, IDLE cycles
# checks: CHECK_RS port addr valid data, CHECK_CLOBBER mask, CHECK_FULL bit
# CHECK_COMMIT finished rd result; rd decimal, data hex, * generated word, - skip
TEST reset_bypass
CHECK_CLOBBER 00000000
CHECK_FULL 0
INSERT ALU 5
CHECK_CLOBBER 00000020
CHECK_COMMIT 0 5 00000000
TEST wb_forward
WB 0 *
CHECK_RS 1 5 1 *
INSERT ALU 5
WB 1 0000beef
CHECK_RS 2 5 1 0000beef
IDLE 1
CHECK_RS 1 5 1 *
CHECK_RS 2 0 0 0
TEST commit
CHECK_COMMIT 1 5 *
COMMIT
CHECK_CLOBBER 00000020
CHECK_COMMIT 1 5 0000beef
COMMIT
CHECK_CLOBBER 00000000
TEST unit_none
INSERT NONE 3
CHECK_CLOBBER 00000008
CHECK_COMMIT 0 3 00000000
IDLE 1
CHECK_COMMIT 1 3 00000000
COMMIT
CHECK_CLOBBER 00000000
TEST full
INSERT ALU 1
INSERT ALU 2
INSERT ALU 3
INSERT ALU 4
INSERT ALU 5
INSERT ALU 6
CHECK_FULL 0
INSERT ALU 7
CHECK_FULL 1
CHECK_CLOBBER 000000fe
INSERT ALU 8
CHECK_CLOBBER 000000fe
WB 3 *
IDLE 1
CHECK_COMMIT 1 1 *
COMMIT
CHECK_FULL 0
CHECK_CLOBBER 000000fc
TEST flush
FLUSH
CHECK_CLOBBER 00000000
CHECK_FULL 0
CHECK_COMMIT 0 - -
INSERT ALU 4
CHECK_CLOBBER 00000010
WB 0 00000abc
IDLE 1
CHECK_COMMIT 1 4 00000abc
COMMIT
CHECK_CLOBBER 00000000

/* tests/tb_scoreboard.sv */
// scoreboard testbench
// replays the command file against the DUT, keeps a small model of the
// table pointers and checks issue, forwarding, clobber, commit and full

`include "sb_macros.svh"

module tb_scoreboard;
  timeunit 1ns;
  timeprecision 10ps;

  logic                         clk_i;
  logic                         rst_ni;
  sb_pkg::sb_instr_t            decoded_instr_i;
  logic                         decoded_valid_i;
  logic                         decoded_ack_o;
  sb_pkg::sb_instr_t            issue_instr_o;
  logic                         issue_valid_o;
  logic                         issue_ack_i;
  sb_pkg::sb_wb_t               wb_i;
  sb_pkg::sb_instr_t            commit_instr_o;
  logic                         commit_ack_i;
  logic                         flush_i;
  logic                         full_o;
  logic [2**`SB_REG_ADDR_W-1:0] clobber_o;
  sb_pkg::reg_addr_t            rs1_addr_i;
  sb_pkg::xlen_t                rs1_o;
  logic                         rs1_valid_o;
  sb_pkg::reg_addr_t            rs2_addr_i;
  sb_pkg::xlen_t                rs2_o;
  logic                         rs2_valid_o;

  // model of the table, entries are taken in order modulo the entry count
  int unsigned occupancy;
  int unsigned next_id;
  int unsigned oldest_id;
  logic [31:0] rand_state;
  logic [31:0] last_rand;
  // run bookkeeping
  string       test_name;
  int unsigned test_checks;
  int unsigned test_errs;
  int unsigned n_tests;
  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned cmd_count;
  // set once outputs were sampled in the current cycle
  bit          at_sample;

  scoreboard i_dut (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // * stands for the last generated write-back word
  function automatic logic [31:0] word_of(input string tok);
    logic [31:0] v;
    int          n;
    v = last_rand;
    if (tok != "*") begin
      n = $sscanf(tok, "%h", v);
    end
    return v;
  endfunction

  function automatic sb_pkg::fu_e fu_of(input string tok);
    case (tok)
      "ALU":    return sb_pkg::ALU;
      "LOAD":   return sb_pkg::LOAD;
      "STORE":  return sb_pkg::STORE;
      "BRANCH": return sb_pkg::BRANCH;
      "CSR":    return sb_pkg::CSR;
      default:  return sb_pkg::NONE;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    n_checks++;
    test_checks++;
    assert (act_v === exp_v) else begin
      $display("ERROR %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
      n_errors++;
      test_errs++;
    end
  endtask

  // ----------------------------------------
  // cycle stepping
  // ----------------------------------------
  // strobes last one cycle only
  task automatic clear_strobes();
    decoded_valid_i = 1'b0;
    issue_ack_i     = 1'b0;
    commit_ack_i    = 1'b0;
    flush_i         = 1'b0;
    wb_i.valid      = 1'b0;
  endtask

  // sample point sits 2 ns before the next edge
  task automatic to_sample();
    if (!at_sample) begin
      #16;
      at_sample = 1'b1;
    end
  endtask

  // close the cycle and stand at the next drive point, 2 ns after the edge
  task automatic end_cycle();
    to_sample();
    @(posedge clk_i);
    #2;
    clear_strobes();
    at_sample = 1'b0;
  endtask

  // a drive after a check goes into the following cycle
  task automatic start_drive();
    if (at_sample) begin
      end_cycle();
    end
  endtask

  task automatic close_test();
    if (test_name != "") begin
      $display("test %-14s %s, %0d checks, %0d errors", test_name,
               (test_errs == 0) ? "ok" : "FAILED", test_checks, test_errs);
      n_tests++;
    end
    test_checks = 0;
    test_errs   = 0;
  endtask

  initial begin : main
    int          fd;
    int          n;
    string       cmd;
    string       a;
    string       b;
    string       line;
    logic [31:0] v;
    logic        accept;
    int unsigned port_v;
    int unsigned addr_v;
    int unsigned flag_v;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    decoded_instr_i = '0;
    wb_i            = '0;
    rs1_addr_i      = '0;
    rs2_addr_i      = '0;
    clear_strobes();
    rand_state = 32'hb8ee3f4b;
    last_rand  = 32'hb8ee3f4b;
    occupancy  = 0;
    next_id    = 0;
    oldest_id  = 0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    fd = $fopen("tests/sb_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file tests/sb_stimulus.txt");
      n_errors++;
    end else begin
      while ($fscanf(fd, "%s", cmd) == 1) begin
        if (cmd.substr(0, 0) == "#") begin
          n = $fgets(line, fd);
        end else begin
          cmd_count++;
          case (cmd)
            "TEST": begin
              close_test();
              n = $fscanf(fd, "%s", test_name);
            end
            // insert with issue ack, the bypass shows it in the same cycle
            "INSERT": begin
              n = $fscanf(fd, "%s %d", a, v);
              // one slot always stays free, so 7 entries mean full
              accept = (occupancy < `SB_NR_ENTRIES - 1);
              start_drive();
              decoded_instr_i    = '0;
              decoded_instr_i.fu = fu_of(a);
              decoded_instr_i.rd = sb_pkg::reg_addr_t'(v);
              decoded_valid_i    = 1'b1;
              issue_ack_i        = 1'b1;
              to_sample();
              check_value("issue valid", accept, issue_valid_o);
              if (accept) begin
                check_value("issue id", next_id, issue_instr_o.trans_id);
                check_value("issue rd", v, issue_instr_o.rd);
                occupancy++;
                next_id = (next_id + 1) % `SB_NR_ENTRIES;
              end
              end_cycle();
            end
            "WB": begin
              n = $fscanf(fd, "%d %s", v, a);
              if (a == "*") begin
                rand_state = lcg_next(rand_state);
                last_rand  = rand_state;
              end
              start_drive();
              wb_i.valid    = 1'b1;
              wb_i.trans_id = sb_pkg::trans_id_t'(v);
              wb_i.data     = word_of(a);
            end
            "COMMIT": begin
              start_drive();
              commit_ack_i = 1'b1;
              end_cycle();
              occupancy--;
              oldest_id = (oldest_id + 1) % `SB_NR_ENTRIES;
            end
            // pointers restart at entry 0
            "FLUSH": begin
              start_drive();
              flush_i = 1'b1;
              end_cycle();
              occupancy = 0;
              next_id   = 0;
              oldest_id = 0;
            end
            "IDLE": begin
              n = $fscanf(fd, "%d", v);
              repeat (v) end_cycle();
            end
            "CHECK_RS": begin
              n = $fscanf(fd, "%d %d %d %s", port_v, addr_v, flag_v, a);
              start_drive();
              if (port_v == 1) begin
                rs1_addr_i = sb_pkg::reg_addr_t'(addr_v);
              end else begin
                rs2_addr_i = sb_pkg::reg_addr_t'(addr_v);
              end
              to_sample();
              check_value("rs valid", flag_v, (port_v == 1) ? rs1_valid_o : rs2_valid_o);
              if (flag_v != 0) begin
                check_value("rs data", word_of(a), (port_v == 1) ? rs1_o : rs2_o);
              end
            end
            "CHECK_CLOBBER": begin
              n = $fscanf(fd, "%s", a);
              to_sample();
              check_value("clobber", word_of(a), clobber_o);
            end
            "CHECK_COMMIT": begin
              n = $fscanf(fd, "%d %s %s", flag_v, b, a);
              to_sample();
              check_value("commit id", oldest_id, commit_instr_o.trans_id);
              check_value("commit finished", flag_v, commit_instr_o.finished);
              if (b != "-") begin
                n = $sscanf(b, "%d", addr_v);
                check_value("commit rd", addr_v, commit_instr_o.rd);
              end
              if (a != "-") begin
                check_value("commit result", word_of(a), commit_instr_o.result);
              end
            end
            "CHECK_FULL": begin
              n = $fscanf(fd, "%d", flag_v);
              to_sample();
              check_value("full", flag_v, full_o);
              check_value("decoded ack", flag_v == 0, decoded_ack_o);
            end
            default: begin
              $display("unknown command %s in test %s", cmd, test_name);
              n_errors++;
            end
          endcase
        end
      end
      $fclose(fd);
    end

    close_test();
    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // 50 cycles per command read plus a fixed margin
  initial begin : watchdog
    while ($time <= 64'd1000 + 64'd1000 * cmd_count) begin
      #20;
    end
    $display("timeout: the run did not finish within the time budget");
    $display("Something failed");
    $finish;
  end

endmodule

/* logic/scoreboard.sv */
// instruction scoreboard top
// in-order issue with decoder bypass, single write-back, single commit,
// clobber vector and two forwarding read ports around one shared table

`include "sb_macros.svh"

module scoreboard (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // decoder side
  input  sb_pkg::sb_instr_t            decoded_instr_i,
  input  logic                         decoded_valid_i,
  output logic                         decoded_ack_o,
  // issue side
  output sb_pkg::sb_instr_t            issue_instr_o,
  output logic                         issue_valid_o,
  input  logic                         issue_ack_i,
  // write-back from the units
  input  sb_pkg::sb_wb_t               wb_i,
  // commit side
  output sb_pkg::sb_instr_t            commit_instr_o,
  input  logic                         commit_ack_i,
  input  logic                         flush_i,
  output logic                         full_o,
  output logic [2**`SB_REG_ADDR_W-1:0] clobber_o,
  // operand read ports
  input  sb_pkg::reg_addr_t            rs1_addr_i,
  output sb_pkg::xlen_t                rs1_o,
  output logic                         rs1_valid_o,
  input  sb_pkg::reg_addr_t            rs2_addr_i,
  output sb_pkg::xlen_t                rs2_o,
  output logic                         rs2_valid_o
);

  sb_pkg::sb_ptrs_t ptrs;
  sb_pkg::sb_slot_t sb_table [`SB_NR_ENTRIES];
  logic             insert_en;
  logic             issue_en;

  sb_pointers i_pointers (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .decoded_valid_i ( decoded_valid_i ),
    .issue_ack_i     ( issue_ack_i     ),
    .commit_ack_i    ( commit_ack_i    ),
    .flush_i         ( flush_i         ),
    .ptrs_o          ( ptrs            ),
    .insert_en_o     ( insert_en       ),
    .issue_en_o      ( issue_en        ),
    .full_o          ( full_o          )
  );

  sb_entry_store i_store (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .decoded_instr_i ( decoded_instr_i ),
    .ptrs_i          ( ptrs            ),
    .insert_en_i     ( insert_en       ),
    .issue_en_i      ( issue_en        ),
    .wb_i            ( wb_i            ),
    .commit_ack_i    ( commit_ack_i    ),
    .flush_i         ( flush_i         ),
    .table_o         ( sb_table        )
  );

  sb_clobber i_clobber (
    .table_i   ( sb_table  ),
    .clobber_o ( clobber_o )
  );

  sb_operand_fwd i_fwd_rs1 (
    .table_i    ( sb_table    ),
    .wb_i       ( wb_i        ),
    .rs_addr_i  ( rs1_addr_i  ),
    .rs_o       ( rs1_o       ),
    .rs_valid_o ( rs1_valid_o )
  );

  sb_operand_fwd i_fwd_rs2 (
    .table_i    ( sb_table    ),
    .wb_i       ( wb_i        ),
    .rs_addr_i  ( rs2_addr_i  ),
    .rs_o       ( rs2_o       ),
    .rs_valid_o ( rs2_valid_o )
  );

  assign decoded_ack_o = ~full_o;

  // ----------------------------------------
  // issue and commit muxes
  // ----------------------------------------
  // synced means insert and issue pointers match, so the trans id holds either way
  always_comb begin
    if (ptrs.synced) begin
      issue_instr_o = decoded_instr_i;
      issue_valid_o = decoded_valid_i & ~full_o;
    end else begin
      issue_instr_o = sb_table[ptrs.issue_ptr].instr;
      issue_valid_o = sb_table[ptrs.issue_ptr].occupied & ~sb_table[ptrs.issue_ptr].issued;
    end
    issue_instr_o.trans_id = ptrs.issue_ptr;

    // oldest entry is always shown, the commit stage checks finished itself
    // the trans id comes from the slot, written there on insert
    commit_instr_o = sb_table[ptrs.commit_ptr].instr;
  end

endmodule

/* logic/sb_operand_fwd.sv */
// operand forwarding for one read port
// matches the register address against the write-back and the finished
// entries, then picks one with a fixed priority

`include "sb_macros.svh"

module sb_operand_fwd (
  input  sb_pkg::sb_slot_t  table_i [`SB_NR_ENTRIES],
  input  sb_pkg::sb_wb_t    wb_i,
  input  sb_pkg::reg_addr_t rs_addr_i,
  output sb_pkg::xlen_t     rs_o,
  output logic              rs_valid_o
);

  // candidate 0 is the write-back, candidate k+1 is table entry k
  localparam int unsigned NR_CAND = `SB_NR_ENTRIES + 1;

  logic          [NR_CAND-1:0] req;
  sb_pkg::xlen_t [NR_CAND-1:0] cand_data;
  logic                        found;

  // ----------------------------------------
  // candidates
  // ----------------------------------------
  // write-back has no rd of its own, look it up at its trans id
  always_comb begin
    req[0]       = wb_i.valid
                   & table_i[wb_i.trans_id].issued
                   & (table_i[wb_i.trans_id].instr.rd == rs_addr_i);
    cand_data[0] = wb_i.data;
    for (int k = 0; k < `SB_NR_ENTRIES; k++) begin
      req[k+1]       = table_i[k].issued
                       & table_i[k].instr.finished
                       & (table_i[k].instr.rd == rs_addr_i);
      cand_data[k+1] = table_i[k].instr.result;
    end
  end

  // ----------------------------------------
  // fixed priority select
  // ----------------------------------------
  // lowest candidate index wins, so write-back beats every entry
  always_comb begin
    found = 1'b0;
    rs_o  = '0;
    for (int i = 0; i < NR_CAND; i++) begin
      if (req[i] && !found) begin
        found = 1'b1;
        rs_o  = cand_data[i];
      end
    end
  end

  // x0 reads always come from the register file
  assign rs_valid_o = found & (|rs_addr_i);

endmodule

/* logic/sb_clobber.sv */
// scoreboard clobber vector
// marks every integer register that an issued entry is still going to write

`include "sb_macros.svh"

module sb_clobber (
  input  sb_pkg::sb_slot_t                  table_i [`SB_NR_ENTRIES],
  output logic [2**`SB_REG_ADDR_W-1:0]      clobber_o
);

  // one request bit per register and entry
  logic [2**`SB_REG_ADDR_W-1:0][`SB_NR_ENTRIES-1:0] pending;

  always_comb begin
    pending = '0;
    // issued and not committed yet, so the register file value is stale
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      pending[table_i[i].instr.rd][i] = table_i[i].issued;
    end

    // x0 is hardwired, never pending
    clobber_o[0] = 1'b0;
    for (int r = 1; r < 2**`SB_REG_ADDR_W; r++) begin
      clobber_o[r] = |pending[r];
    end
  end

endmodule

/* logic/sb_entry_store.sv */
// scoreboard entry table
// owns the circular table and applies insert, issue, write-back,
// unit none completion, commit and flush to it every cycle

`include "sb_macros.svh"

module sb_entry_store (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  sb_pkg::sb_instr_t decoded_instr_i,
  input  sb_pkg::sb_ptrs_t  ptrs_i,
  input  logic              insert_en_i,
  input  logic              issue_en_i,
  input  sb_pkg::sb_wb_t    wb_i,
  input  logic              commit_ack_i,
  input  logic              flush_i,
  output sb_pkg::sb_slot_t  table_o [`SB_NR_ENTRIES]
);

  sb_pkg::sb_slot_t table_q [`SB_NR_ENTRIES];
  sb_pkg::sb_slot_t table_d [`SB_NR_ENTRIES];

  // updates below run in priority order, a later one overrides an earlier one
  always_comb begin
    table_d = table_q;

    // ----------------------------------------
    // insert
    // ----------------------------------------
    if (insert_en_i) begin
      table_d[ptrs_i.insert_ptr].occupied       = 1'b1;
      table_d[ptrs_i.insert_ptr].issued         = 1'b0;
      table_d[ptrs_i.insert_ptr].instr          = decoded_instr_i;
      // a fresh entry has no result yet
      table_d[ptrs_i.insert_ptr].instr.finished = 1'b0;
      table_d[ptrs_i.insert_ptr].instr.trans_id = ptrs_i.insert_ptr;
    end

    // issue mark, covers the bypass case too since both pointers match then
    if (issue_en_i) begin
      table_d[ptrs_i.issue_ptr].issued = 1'b1;
    end

    // ----------------------------------------
    // unit none
    // ----------------------------------------
    // nothing executes these, they finish on their own the cycle after insert
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (table_q[i].occupied && table_q[i].instr.fu == sb_pkg::NONE) begin
        table_d[i].instr.finished = 1'b1;
      end
    end

    // ----------------------------------------
    // write-back
    // ----------------------------------------
    // a late result for an entry that was flushed and reused is dropped
    if (wb_i.valid && table_q[wb_i.trans_id].issued) begin
      table_d[wb_i.trans_id].instr.result   = wb_i.data;
      table_d[wb_i.trans_id].instr.finished = 1'b1;
    end

    // ----------------------------------------
    // commit
    // ----------------------------------------
    if (commit_ack_i) begin
      table_d[ptrs_i.commit_ptr].occupied       = 1'b0;
      table_d[ptrs_i.commit_ptr].issued         = 1'b0;
      table_d[ptrs_i.commit_ptr].instr.finished = 1'b0;
    end

    // full flush, payload stays but no slot is live anymore
    if (flush_i) begin
      for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
        table_d[i].occupied       = 1'b0;
        table_d[i].issued         = 1'b0;
        table_d[i].instr.finished = 1'b0;
      end
    end
  end

  // slot flags are the control state of the whole scoreboard
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      table_q <= '{default: '0};
    end else begin
      table_q <= table_d;
    end
  end

  assign table_o = table_q;

endmodule

/* logic/sb_pointers.sv */
// scoreboard pointer unit
// keeps insert, issue and commit pointers plus the occupancy counts,
// derives full, synced and the insert and issue strobes

`include "sb_macros.svh"

module sb_pointers (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             decoded_valid_i,
  input  logic             issue_ack_i,
  input  logic             commit_ack_i,
  input  logic             flush_i,
  output sb_pkg::sb_ptrs_t ptrs_o,
  output logic             insert_en_o,
  output logic             issue_en_o,
  output logic             full_o
);

  sb_pkg::trans_id_t insert_ptr_q, insert_ptr_d;
  sb_pkg::trans_id_t issue_ptr_q, issue_ptr_d;
  sb_pkg::trans_id_t commit_ptr_q, commit_ptr_d;
  // entries inserted and not yet committed
  sb_pkg::trans_id_t insert_cnt_q, insert_cnt_d;
  // entries issued and not yet committed
  sb_pkg::trans_id_t issue_cnt_q, issue_cnt_d;
  logic              synced;

  // all ones means 7 occupied, the last slot always stays free
  assign full_o = &insert_cnt_q;
  // nothing waiting in the table, decoder goes straight to issue
  assign synced = (insert_cnt_q == issue_cnt_q);

  assign insert_en_o = decoded_valid_i & ~full_o;
  // when synced only the bypassed instruction can be issued
  assign issue_en_o  = issue_ack_i & (~synced | insert_en_o);

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    insert_ptr_d = insert_ptr_q + sb_pkg::trans_id_t'(insert_en_o);
    issue_ptr_d  = issue_ptr_q + sb_pkg::trans_id_t'(issue_en_o);
    commit_ptr_d = commit_ptr_q + sb_pkg::trans_id_t'(commit_ack_i);
    insert_cnt_d = insert_cnt_q + sb_pkg::trans_id_t'(insert_en_o)
                   - sb_pkg::trans_id_t'(commit_ack_i);
    issue_cnt_d  = issue_cnt_q + sb_pkg::trans_id_t'(issue_en_o)
                   - sb_pkg::trans_id_t'(commit_ack_i);
    // flush drops everything in flight
    if (flush_i) begin
      insert_ptr_d = '0;
      issue_ptr_d  = '0;
      commit_ptr_d = '0;
      insert_cnt_d = '0;
      issue_cnt_d  = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insert_ptr_q <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      insert_cnt_q <= '0;
      issue_cnt_q  <= '0;
    end else begin
      insert_ptr_q <= insert_ptr_d;
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
      insert_cnt_q <= insert_cnt_d;
      issue_cnt_q  <= issue_cnt_d;
    end
  end

  assign ptrs_o = '{
    insert_ptr: insert_ptr_q,
    issue_ptr:  issue_ptr_q,
    commit_ptr: commit_ptr_q,
    synced:     synced
  };

endmodule

/* logic/sb_pkg.sv */
// scoreboard types
// unit encoding and the records moved between the scoreboard blocks

`include "sb_macros.svh"

package sb_pkg;

  // entry index doubles as transaction id
  typedef logic [$clog2(`SB_NR_ENTRIES)-1:0] trans_id_t;
  typedef logic [`SB_REG_ADDR_W-1:0]         reg_addr_t;
  typedef logic [`SB_XLEN-1:0]               xlen_t;

  // functional unit that executes the instruction
  typedef enum logic [2:0] {
    NONE,
    ALU,
    LOAD,
    STORE,
    BRANCH,
    CSR
  } fu_e;

  // decoded instruction as seen by issue and commit
  typedef struct packed {
    fu_e       fu;
    reg_addr_t rd;
    xlen_t     result;
    logic      finished;
    trans_id_t trans_id;
  } sb_instr_t;

  // one table slot
  typedef struct packed {
    logic      occupied;
    logic      issued;
    sb_instr_t instr;
  } sb_slot_t;

  // result coming back from a unit
  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    xlen_t     data;
  } sb_wb_t;

  // pointer bundle for the peers
  typedef struct packed {
    trans_id_t insert_ptr;
    trans_id_t issue_ptr;
    trans_id_t commit_ptr;
    logic      synced;
  } sb_ptrs_t;

endpackage

/* logic/sb_macros.svh */
// scoreboard sizing macros
// entry count, register address width and data width shared by all blocks

`ifndef SB_MACROS_SVH
`define SB_MACROS_SVH

// number of table entries, must stay a power of two
`define SB_NR_ENTRIES 8

// integer register address width
`define SB_REG_ADDR_W 5

// data word width
`define SB_XLEN 32

`endif
